// File: src.f
+incdir+include
src/mips_id_pkg.sv
src/inst_decoder.sv
src/operand_fetch.sv
src/branch_resolve.sv
src/id_ex_reg.sv
src/id_stage.sv
tests/id_stage_asserts.sv
tests/tb_id_stage.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module tb_id_stage -o sim_id_stage &&
	./obj_dir/sim_id_stage > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tests/tb_id_stage.sv
`timescale 1ns/1ps
`include "mips_id_settings.svh"

module tb_id_stage;

	localparam time PERIOD      = 100;
	localparam int  TEST_CYCLES = 40;
	localparam int  MARGIN      = 20;

	logic                   clk;
	logic                   rst_n_i;
	mips_id_pkg::word_t     pc_i;
	mips_id_pkg::word_t     inst_i;
	mips_id_pkg::aluop_t    ex_aluop_i;
	logic                   ex_wreg_i;
	mips_id_pkg::reg_addr_t ex_wd_i;
	mips_id_pkg::word_t     ex_wdata_i;
	logic                   mem_wreg_i;
	mips_id_pkg::reg_addr_t mem_wd_i;
	mips_id_pkg::word_t     mem_wdata_i;
	mips_id_pkg::word_t     reg1_data_i;
	mips_id_pkg::word_t     reg2_data_i;
	logic                   reg1_read_o;
	logic                   reg2_read_o;
	mips_id_pkg::reg_addr_t reg1_addr_o;
	mips_id_pkg::reg_addr_t reg2_addr_o;
	logic                   stall_o;
	logic                   branch_flag_o;
	mips_id_pkg::word_t     branch_target_o;
	mips_id_pkg::aluop_t    ex_aluop_o;
	mips_id_pkg::alusel_t   ex_alusel_o;
	mips_id_pkg::word_t     ex_reg1_o;
	mips_id_pkg::word_t     ex_reg2_o;
	mips_id_pkg::reg_addr_t ex_wd_o;
	logic                   ex_wreg_o;
	mips_id_pkg::word_t     ex_link_addr_o;
	mips_id_pkg::word_t     ex_inst_o;
	logic                   ex_in_delayslot_o;

	id_stage UUT (.*);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	initial begin
		#((TEST_CYCLES + MARGIN) * PERIOD);
		$display("watchdog expired before the tests finished");
		$display("Test FAILED");
		$fatal(1, "timeout");
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
	                               input logic [31:0] exp);
		$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
		$display("Test FAILED");
		$fatal(1, "compare mismatch");
	endtask

	task automatic check_word(input string name, input mips_id_pkg::word_t got,
	                          input mips_id_pkg::word_t exp);
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic check_addr(input string name, input mips_id_pkg::reg_addr_t got,
	                          input mips_id_pkg::reg_addr_t exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic check_aluop(input string name, input mips_id_pkg::aluop_t got,
	                           input mips_id_pkg::aluop_t exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic check_alusel(input string name, input mips_id_pkg::alusel_t got,
	                            input mips_id_pkg::alusel_t exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	function automatic mips_id_pkg::word_t r_format(input mips_id_pkg::reg_addr_t rs,
		input mips_id_pkg::reg_addr_t rt, input mips_id_pkg::reg_addr_t rd,
		input logic [4:0] shamt, input logic [5:0] funct);
		return {`MIPS_OP_SPECIAL, rs, rt, rd, shamt, funct};
	endfunction

	function automatic mips_id_pkg::word_t i_format(input logic [5:0] op,
		input mips_id_pkg::reg_addr_t rs, input mips_id_pkg::reg_addr_t rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic tick;
		@(posedge clk);
		#1;
	endtask

	task automatic wait_comb;
		#10;
	endtask

	task automatic idle_inputs;
		ex_aluop_i  = `MIPS_ALUOP_NOP;
		ex_wreg_i   = 1'b0;
		ex_wd_i     = '0;
		ex_wdata_i  = '0;
		mem_wreg_i  = 1'b0;
		mem_wd_i    = '0;
		mem_wdata_i = '0;
	endtask

	task automatic issue(input mips_id_pkg::word_t pc, input mips_id_pkg::word_t inst,
	                     input mips_id_pkg::word_t rf1, input mips_id_pkg::word_t rf2);
		pc_i        = pc;
		inst_i      = inst;
		reg1_data_i = rf1;
		reg2_data_i = rf2;
	endtask

	// register file requests, addresses only matter when read
	task automatic check_read_ports(input logic rd1, input logic rd2,
		input mips_id_pkg::reg_addr_t a1, input mips_id_pkg::reg_addr_t a2);
		wait_comb;
		check_bit("reg1_read_o", reg1_read_o, rd1);
		check_bit("reg2_read_o", reg2_read_o, rd2);
		if (rd1)
			check_addr("reg1_addr_o", reg1_addr_o, a1);
		if (rd2)
			check_addr("reg2_addr_o", reg2_addr_o, a2);
	endtask

	task automatic check_reset_values;
		check_aluop("ex_aluop_o", ex_aluop_o, `MIPS_ALUOP_NOP);
		check_alusel("ex_alusel_o", ex_alusel_o, `MIPS_RES_NOP);
		check_word("ex_reg1_o", ex_reg1_o, '0);
		check_word("ex_reg2_o", ex_reg2_o, '0);
		check_addr("ex_wd_o", ex_wd_o, '0);
		check_bit("ex_wreg_o", ex_wreg_o, 1'b0);
		check_word("ex_link_addr_o", ex_link_addr_o, '0);
		check_word("ex_inst_o", ex_inst_o, '0);
		check_bit("ex_in_delayslot_o", ex_in_delayslot_o, 1'b0);
	endtask

	task automatic check_decoded(input mips_id_pkg::aluop_t aluop,
		input mips_id_pkg::alusel_t alusel, input mips_id_pkg::reg_addr_t wd,
		input logic wreg, input mips_id_pkg::word_t r1, input mips_id_pkg::word_t r2);
		check_aluop("ex_aluop_o", ex_aluop_o, aluop);
		check_alusel("ex_alusel_o", ex_alusel_o, alusel);
		check_addr("ex_wd_o", ex_wd_o, wd);
		check_bit("ex_wreg_o", ex_wreg_o, wreg);
		check_word("ex_reg1_o", ex_reg1_o, r1);
		check_word("ex_reg2_o", ex_reg2_o, r2);
	endtask

	task automatic test_reset;
		issue(32'h0000_0100, i_format(`MIPS_OP_ADDI, 5'd1, 5'd2, 16'h0010), 32'h1234, '0);
		repeat (10) begin
			tick;
			check_reset_values;
		end
		rst_n_i = 1'b1;
		issue(32'h0000_0104, 32'h0000_0001, '0, '0);  // funct 000001 is not decoded
		wait_comb;
		check_reset_values;
		tick;
		check_aluop("ex_aluop_o", ex_aluop_o, `MIPS_ALUOP_NOP);
		check_alusel("ex_alusel_o", ex_alusel_o, `MIPS_RES_NOP);
		check_bit("ex_wreg_o", ex_wreg_o, 1'b0);
	endtask

	task automatic test_alu_decode;
		mips_id_pkg::word_t d1;
		mips_id_pkg::word_t d2;
		logic [15:0]        imm;
		d1  = $urandom();
		d2  = $urandom();
		imm = 16'($urandom()) | 16'h8000;  // top bit set to expose the extension
		issue(32'h0000_0200, i_format(`MIPS_OP_ORI, 5'd5, 5'd6, imm), d1, d2);
		check_read_ports(1'b1, 1'b0, 5'd5, 5'd6);
		tick;
		check_decoded(`MIPS_ALUOP_OR, `MIPS_RES_LOGIC, 5'd6, 1'b1, d1, {16'h0, imm});
		issue(32'h0000_0204, i_format(`MIPS_OP_LUI, 5'd0, 5'd7, imm), '0, d2);
		check_read_ports(1'b1, 1'b0, 5'd0, 5'd7);
		tick;
		check_decoded(`MIPS_ALUOP_OR, `MIPS_RES_LOGIC, 5'd7, 1'b1, '0, {imm, 16'h0});
		issue(32'h0000_0208, i_format(`MIPS_OP_ADDI, 5'd3, 5'd4, imm), d1, d2);
		check_read_ports(1'b1, 1'b0, 5'd3, 5'd4);
		tick;
		check_decoded(`MIPS_ALUOP_ADDI, `MIPS_RES_ARITHMETIC, 5'd4, 1'b1, d1,
		              {{16{imm[15]}}, imm});
		issue(32'h0000_020c, r_format(5'd8, 5'd9, 5'd10, 5'd0, `MIPS_FUNCT_SLT), d1, d2);
		check_read_ports(1'b1, 1'b1, 5'd8, 5'd9);
		tick;
		check_decoded(`MIPS_ALUOP_SLT, `MIPS_RES_ARITHMETIC, 5'd10, 1'b1, d1, d2);
		issue(32'h0000_0210, r_format(5'd0, 5'd11, 5'd12, 5'd5, `MIPS_FUNCT_SLL), d1, d2);
		check_read_ports(1'b0, 1'b1, 5'd0, 5'd11);
		tick;
		check_decoded(`MIPS_ALUOP_SLL, `MIPS_RES_SHIFT, 5'd12, 1'b1, 32'd5, d2);
		check_word("ex_inst_o", ex_inst_o,
		           r_format(5'd0, 5'd11, 5'd12, 5'd5, `MIPS_FUNCT_SLL));
	endtask

	task automatic forward_case(input logic ex_en, input logic mem_en,
		input mips_id_pkg::word_t rf, input mips_id_pkg::word_t exd,
		input mips_id_pkg::word_t memd, input mips_id_pkg::word_t expected);
		ex_aluop_i  = `MIPS_ALUOP_ADDU;
		ex_wreg_i   = ex_en;
		ex_wd_i     = 5'd13;
		ex_wdata_i  = exd;
		mem_wreg_i  = mem_en;
		mem_wd_i    = 5'd13;
		mem_wdata_i = memd;
		issue(32'h0000_0300, r_format(5'd13, 5'd14, 5'd2, 5'd0, `MIPS_FUNCT_ADDU), rf, '0);
		wait_comb;
		check_bit("stall_o", stall_o, 1'b0);
		tick;
		check_word("ex_reg1_o", ex_reg1_o, expected);
		check_aluop("ex_aluop_o", ex_aluop_o, `MIPS_ALUOP_ADDU);
	endtask

	task automatic test_forwarding;
		mips_id_pkg::word_t rf;
		mips_id_pkg::word_t exd;
		mips_id_pkg::word_t memd;
		rf   = $urandom();
		exd  = $urandom();
		memd = $urandom();
		forward_case(1'b1, 1'b1, rf, exd, memd, exd);
		forward_case(1'b0, 1'b1, rf, exd, memd, memd);
		forward_case(1'b0, 1'b0, rf, exd, memd, rf);
		idle_inputs;
	endtask

	task automatic test_load_use;
		mips_id_pkg::word_t loaded;
		mips_id_pkg::word_t rf2;
		loaded      = $urandom();
		rf2         = $urandom();
		ex_aluop_i  = `MIPS_ALUOP_LW;
		ex_wreg_i   = 1'b1;
		ex_wd_i     = 5'd15;
		ex_wdata_i  = $urandom();  // load address, not the data
		issue(32'h0000_0400, r_format(5'd15, 5'd17, 5'd16, 5'd0, `MIPS_FUNCT_ADDU),
		      $urandom(), rf2);
		wait_comb;
		check_bit("stall_o", stall_o, 1'b1);
		tick;
		check_aluop("ex_aluop_o", ex_aluop_o, `MIPS_ALUOP_NOP);
		check_alusel("ex_alusel_o", ex_alusel_o, `MIPS_RES_NOP);
		check_bit("ex_wreg_o", ex_wreg_o, 1'b0);
		check_word("ex_reg1_o", ex_reg1_o, '0);
		check_word("ex_reg2_o", ex_reg2_o, '0);
		check_bit("ex_in_delayslot_o", ex_in_delayslot_o, 1'b0);
		idle_inputs;
		mem_wreg_i  = 1'b1;  // the load has moved on to MEM
		mem_wd_i    = 5'd15;
		mem_wdata_i = loaded;
		wait_comb;
		check_bit("stall_o", stall_o, 1'b0);
		tick;
		check_decoded(`MIPS_ALUOP_ADDU, `MIPS_RES_ARITHMETIC, 5'd16, 1'b1, loaded, rf2);
		idle_inputs;
	endtask

	task automatic branch_case(input logic exp_flag, input mips_id_pkg::word_t exp_target);
		wait_comb;
		check_bit("stall_o", stall_o, 1'b0);
		check_bit("branch_flag_o", branch_flag_o, exp_flag);
		if (exp_flag)
			check_word("branch_target_o", branch_target_o, exp_target);
		tick;
	endtask

	task automatic test_branches;
		mips_id_pkg::word_t pc;
		mips_id_pkg::word_t v;
		mips_id_pkg::word_t tgt;
		logic [25:0]        idx;
		pc  = 32'h8fff_fffc;  // pc+4 crosses into the next 256 MB region
		v   = $urandom();
		idx = 26'($urandom());
		issue(pc, i_format(`MIPS_OP_BEQ, 5'd1, 5'd2, 16'hfff0), v, v);
		branch_case(1'b1, pc + 32'd4 + {{14{1'b1}}, 16'hfff0, 2'b00});
		issue(pc, i_format(`MIPS_OP_BEQ, 5'd1, 5'd2, 16'hfff0), v, v ^ 32'h1);
		branch_case(1'b0, '0);
		issue(pc, i_format(`MIPS_OP_REGIMM, 5'd3, `MIPS_RT_BLTZ, 16'h0040),
		      v | 32'h8000_0000, '0);
		branch_case(1'b1, pc + 32'd4 + 32'h0000_0100);
		tgt = pc + 32'd4;
		tgt = {tgt[31:28], idx, 2'b00};
		issue(pc, {`MIPS_OP_J, idx}, '0, '0);
		branch_case(1'b1, tgt);
		issue(pc, r_format(5'd4, 5'd0, 5'd0, 5'd0, `MIPS_FUNCT_JR), {v[31:2], 2'b00}, '0);
		branch_case(1'b1, {v[31:2], 2'b00});
		issue(pc, {`MIPS_OP_JAL, idx}, '0, '0);
		branch_case(1'b1, tgt);
		check_addr("ex_wd_o", ex_wd_o, `MIPS_LINK_REG);
		check_bit("ex_wreg_o", ex_wreg_o, 1'b1);
		check_word("ex_link_addr_o", ex_link_addr_o, pc + 32'd8);
		issue(pc, i_format(`MIPS_OP_REGIMM, 5'd5, `MIPS_RT_BGEZAL, 16'h0008),
		      v & 32'h7fff_ffff, '0);
		branch_case(1'b1, pc + 32'd4 + 32'h0000_0020);
		check_addr("ex_wd_o", ex_wd_o, `MIPS_LINK_REG);
		check_bit("ex_wreg_o", ex_wreg_o, 1'b1);
		check_word("ex_link_addr_o", ex_link_addr_o, pc + 32'd8);
	endtask

	task automatic test_delay_slot;
		mips_id_pkg::word_t v;
		v = $urandom();
		issue(32'h0000_0500, i_format(`MIPS_OP_BEQ, 5'd1, 5'd1, 16'h0010), v, v);
		branch_case(1'b1, 32'h0000_0504 + 32'h0000_0040);
		issue(32'h0000_0504, i_format(`MIPS_OP_ORI, 5'd2, 5'd3, 16'h00ff), v, '0);
		branch_case(1'b0, '0);
		check_bit("ex_in_delayslot_o", ex_in_delayslot_o, 1'b1);
		issue(32'h0000_0508, i_format(`MIPS_OP_ORI, 5'd2, 5'd3, 16'h00ff), v, '0);
		branch_case(1'b0, '0);
		check_bit("ex_in_delayslot_o", ex_in_delayslot_o, 1'b0);
	endtask

	initial begin
		int unsigned seed_ret;
		seed_ret = $urandom(32'h34ea_2b79);
		rst_n_i  = 1'b0;
		idle_inputs;
		issue('0, '0, '0, '0);
		test_reset;
		test_alu_decode;
		test_forwarding;
		test_load_use;
		test_branches;
		test_delay_slot;
		$display("Test OK");
		$finish;
	end

endmodule

// File: tests/id_stage_asserts.sv
`timescale 1ns/1ps
`include "mips_id_settings.svh"

module id_stage_asserts (
	input logic                   clk,
	input logic                   rst_n_i,
	input logic                   stall_i,
	input logic                   branch_flag_i,
	input logic                   reg1_read_i,
	input mips_id_pkg::word_t     inst_i,
	input mips_id_pkg::aluop_t    ex_aluop_i,
	input mips_id_pkg::alusel_t   ex_alusel_i,
	input mips_id_pkg::word_t     ex_reg1_i,
	input mips_id_pkg::word_t     ex_reg2_i,
	input mips_id_pkg::reg_addr_t ex_wd_i,
	input logic                   ex_wreg_i,
	input mips_id_pkg::word_t     ex_link_addr_i,
	input mips_id_pkg::word_t     ex_inst_i,
	input logic                   ex_in_delayslot_i
);

	// a stalled edge loads a bubble
	bubble_no_write: assert property (@(posedge clk) disable iff (!rst_n_i)
		stall_i |=> !ex_wreg_i)
		else $error("write enable reached EX after a stall edge");

	jump_reads_no_reg: assert property (@(posedge clk)
		(branch_flag_i && ((inst_i[31:26] == `MIPS_OP_J) || (inst_i[31:26] == `MIPS_OP_JAL)))
		|-> !reg1_read_i)
		else $error("J or JAL read a source register");

	ex_outputs_known: assert property (@(posedge clk)
		rst_n_i |-> !$isunknown({ex_aluop_i, ex_alusel_i, ex_reg1_i, ex_reg2_i, ex_wd_i,
		                         ex_wreg_i, ex_link_addr_i, ex_inst_i, ex_in_delayslot_i}))
		else $error("an EX-side output is unknown after reset");

endmodule

bind id_stage id_stage_asserts u_asserts (
	.clk               (clk),
	.rst_n_i           (rst_n_i),
	.stall_i           (stall_o),
	.branch_flag_i     (branch_flag_o),
	.reg1_read_i       (reg1_read_o),
	.inst_i            (inst_i),
	.ex_aluop_i        (ex_aluop_o),
	.ex_alusel_i       (ex_alusel_o),
	.ex_reg1_i         (ex_reg1_o),
	.ex_reg2_i         (ex_reg2_o),
	.ex_wd_i           (ex_wd_o),
	.ex_wreg_i         (ex_wreg_o),
	.ex_link_addr_i    (ex_link_addr_o),
	.ex_inst_i         (ex_inst_o),
	.ex_in_delayslot_i (ex_in_delayslot_o)
);

// File: src/id_stage.sv
`timescale 1ns/1ps

module id_stage (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  mips_id_pkg::word_t     pc_i,
	input  mips_id_pkg::word_t     inst_i,
	input  mips_id_pkg::aluop_t    ex_aluop_i,
	input  logic                   ex_wreg_i,
	input  mips_id_pkg::reg_addr_t ex_wd_i,
	input  mips_id_pkg::word_t     ex_wdata_i,
	input  logic                   mem_wreg_i,
	input  mips_id_pkg::reg_addr_t mem_wd_i,
	input  mips_id_pkg::word_t     mem_wdata_i,
	input  mips_id_pkg::word_t     reg1_data_i,
	input  mips_id_pkg::word_t     reg2_data_i,
	output logic                   reg1_read_o,
	output logic                   reg2_read_o,
	output mips_id_pkg::reg_addr_t reg1_addr_o,
	output mips_id_pkg::reg_addr_t reg2_addr_o,
	output logic                   stall_o,
	output logic                   branch_flag_o,
	output mips_id_pkg::word_t     branch_target_o,
	output mips_id_pkg::aluop_t    ex_aluop_o,
	output mips_id_pkg::alusel_t   ex_alusel_o,
	output mips_id_pkg::word_t     ex_reg1_o,
	output mips_id_pkg::word_t     ex_reg2_o,
	output mips_id_pkg::reg_addr_t ex_wd_o,
	output logic                   ex_wreg_o,
	output mips_id_pkg::word_t     ex_link_addr_o,
	output mips_id_pkg::word_t     ex_inst_o,
	output logic                   ex_in_delayslot_o
);

	mips_id_pkg::aluop_t    aluop;
	mips_id_pkg::alusel_t   alusel;
	mips_id_pkg::reg_addr_t wd;
	logic                   wreg;
	mips_id_pkg::word_t     imm;
	mips_id_pkg::br_kind_t  br_kind;
	logic                   link;
	mips_id_pkg::word_t     reg1;
	mips_id_pkg::word_t     reg2;
	mips_id_pkg::word_t     link_addr;

	inst_decoder u_decoder (
		.inst_i      (inst_i),
		.aluop_o     (aluop),
		.alusel_o    (alusel),
		.reg1_read_o (reg1_read_o),
		.reg2_read_o (reg2_read_o),
		.reg1_addr_o (reg1_addr_o),
		.reg2_addr_o (reg2_addr_o),
		.wd_o        (wd),
		.wreg_o      (wreg),
		.imm_o       (imm),
		.br_kind_o   (br_kind),
		.link_o      (link)
	);

	operand_fetch u_operands (
		.reg1_read_i (reg1_read_o),
		.reg2_read_i (reg2_read_o),
		.reg1_addr_i (reg1_addr_o),
		.reg2_addr_i (reg2_addr_o),
		.imm_i       (imm),
		.ex_aluop_i  (ex_aluop_i),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.reg1_data_i (reg1_data_i),
		.reg2_data_i (reg2_data_i),
		.reg1_o      (reg1),
		.reg2_o      (reg2),
		.stall_o     (stall_o)
	);

	branch_resolve u_branch (
		.pc_i            (pc_i),
		.inst_i          (inst_i),
		.br_kind_i       (br_kind),
		.link_i          (link),
		.reg1_i          (reg1),
		.reg2_i          (reg2),
		.branch_flag_o   (branch_flag_o),
		.branch_target_o (branch_target_o),
		.link_addr_o     (link_addr)
	);

	id_ex_reg u_id_ex (
		.clk               (clk),
		.rst_n_i           (rst_n_i),
		.stall_i           (stall_o),
		.branch_flag_i     (branch_flag_o),
		.aluop_i           (aluop),
		.alusel_i          (alusel),
		.reg1_i            (reg1),
		.reg2_i            (reg2),
		.wd_i              (wd),
		.wreg_i            (wreg),
		.link_addr_i       (link_addr),
		.inst_i            (inst_i),
		.ex_aluop_o        (ex_aluop_o),
		.ex_alusel_o       (ex_alusel_o),
		.ex_reg1_o         (ex_reg1_o),
		.ex_reg2_o         (ex_reg2_o),
		.ex_wd_o           (ex_wd_o),
		.ex_wreg_o         (ex_wreg_o),
		.ex_link_addr_o    (ex_link_addr_o),
		.ex_inst_o         (ex_inst_o),
		.ex_in_delayslot_o (ex_in_delayslot_o)
	);

endmodule

// File: src/id_ex_reg.sv
`timescale 1ns/1ps
`include "mips_id_settings.svh"

module id_ex_reg (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   stall_i,
	input  logic                   branch_flag_i,
	input  mips_id_pkg::aluop_t    aluop_i,
	input  mips_id_pkg::alusel_t   alusel_i,
	input  mips_id_pkg::word_t     reg1_i,
	input  mips_id_pkg::word_t     reg2_i,
	input  mips_id_pkg::reg_addr_t wd_i,
	input  logic                   wreg_i,
	input  mips_id_pkg::word_t     link_addr_i,
	input  mips_id_pkg::word_t     inst_i,
	output mips_id_pkg::aluop_t    ex_aluop_o,
	output mips_id_pkg::alusel_t   ex_alusel_o,
	output mips_id_pkg::word_t     ex_reg1_o,
	output mips_id_pkg::word_t     ex_reg2_o,
	output mips_id_pkg::reg_addr_t ex_wd_o,
	output logic                   ex_wreg_o,
	output mips_id_pkg::word_t     ex_link_addr_o,
	output mips_id_pkg::word_t     ex_inst_o,
	output logic                   ex_in_delayslot_o
);

	logic in_delayslot;  // instruction now in ID follows a taken branch

	always_ff @(posedge clk) begin
		if (!rst_n_i || stall_i) begin
			ex_aluop_o        <= `MIPS_ALUOP_NOP;  // bubble on stall
			ex_alusel_o       <= `MIPS_RES_NOP;
			ex_reg1_o         <= '0;
			ex_reg2_o         <= '0;
			ex_wd_o           <= '0;
			ex_wreg_o         <= 1'b0;
			ex_link_addr_o    <= '0;
			ex_inst_o         <= '0;
			ex_in_delayslot_o <= 1'b0;
		end else begin
			ex_aluop_o        <= aluop_i;
			ex_alusel_o       <= alusel_i;
			ex_reg1_o         <= reg1_i;
			ex_reg2_o         <= reg2_i;
			ex_wd_o           <= wd_i;
			ex_wreg_o         <= wreg_i;
			ex_link_addr_o    <= link_addr_i;
			ex_inst_o         <= inst_i;
			ex_in_delayslot_o <= in_delayslot;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			in_delayslot <= 1'b0;
		else if (!stall_i)
			in_delayslot <= branch_flag_i;  // held while stalled
	end

endmodule

// File: src/branch_resolve.sv
`timescale 1ns/1ps
`include "mips_id_settings.svh"

module branch_resolve (
	input  mips_id_pkg::word_t    pc_i,
	input  mips_id_pkg::word_t    inst_i,
	input  mips_id_pkg::br_kind_t br_kind_i,
	input  logic                  link_i,
	input  mips_id_pkg::word_t    reg1_i,
	input  mips_id_pkg::word_t    reg2_i,
	output logic                  branch_flag_o,
	output mips_id_pkg::word_t    branch_target_o,
	output mips_id_pkg::word_t    link_addr_o
);

	mips_id_pkg::word_t pc_plus_4;
	mips_id_pkg::word_t pc_plus_8;
	mips_id_pkg::word_t br_offset;

	assign pc_plus_4   = pc_i + 32'd4;
	assign pc_plus_8   = pc_i + 32'd8;  // skips the delay slot
	assign br_offset   = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
	assign link_addr_o = link_i ? pc_plus_8 : '0;

	always_comb begin
		case (br_kind_i)
			`MIPS_BR_J, `MIPS_BR_JR: branch_flag_o = 1'b1;
			`MIPS_BR_EQ:  branch_flag_o = (reg1_i == reg2_i);
			`MIPS_BR_NE:  branch_flag_o = (reg1_i != reg2_i);
			`MIPS_BR_GTZ: branch_flag_o = ~reg1_i[31] && (reg1_i != '0);
			`MIPS_BR_LEZ: branch_flag_o = reg1_i[31] || (reg1_i == '0);
			`MIPS_BR_GEZ: branch_flag_o = ~reg1_i[31];
			`MIPS_BR_LTZ: branch_flag_o = reg1_i[31];
			default:      branch_flag_o = 1'b0;
		endcase
	end

	always_comb begin
		if (!branch_flag_o)
			branch_target_o = '0;
		else if (br_kind_i == `MIPS_BR_J)
			branch_target_o = {pc_plus_4[31:28], inst_i[25:0], 2'b00};  // region of the slot
		else if (br_kind_i == `MIPS_BR_JR)
			branch_target_o = reg1_i;
		else
			branch_target_o = pc_plus_4 + br_offset;
	end

endmodule

// File: src/operand_fetch.sv
`timescale 1ns/1ps
`include "mips_id_settings.svh"

module operand_fetch (
	input  logic                   reg1_read_i,
	input  logic                   reg2_read_i,
	input  mips_id_pkg::reg_addr_t reg1_addr_i,
	input  mips_id_pkg::reg_addr_t reg2_addr_i,
	input  mips_id_pkg::word_t     imm_i,
	input  mips_id_pkg::aluop_t    ex_aluop_i,
	input  logic                   ex_wreg_i,
	input  mips_id_pkg::reg_addr_t ex_wd_i,
	input  mips_id_pkg::word_t     ex_wdata_i,
	input  logic                   mem_wreg_i,
	input  mips_id_pkg::reg_addr_t mem_wd_i,
	input  mips_id_pkg::word_t     mem_wdata_i,
	input  mips_id_pkg::word_t     reg1_data_i,
	input  mips_id_pkg::word_t     reg2_data_i,
	output mips_id_pkg::word_t     reg1_o,
	output mips_id_pkg::word_t     reg2_o,
	output logic                   stall_o
);

	logic ex_is_load;

	// newest producer wins, then the register file, then the immediate
	function automatic mips_id_pkg::word_t select_operand(
		input logic                   rd_en,
		input mips_id_pkg::reg_addr_t addr,
		input mips_id_pkg::word_t     rf_data
	);
		if (rd_en && ex_wreg_i && (ex_wd_i == addr))
			return ex_wdata_i;
		else if (rd_en && mem_wreg_i && (mem_wd_i == addr))
			return mem_wdata_i;
		else if (rd_en)
			return rf_data;
		else
			return imm_i;
	endfunction

	// load data arrives in MEM, too late to forward from EX
	assign ex_is_load = (ex_aluop_i == `MIPS_ALUOP_LB) || (ex_aluop_i == `MIPS_ALUOP_LBU) ||
	                    (ex_aluop_i == `MIPS_ALUOP_LH) || (ex_aluop_i == `MIPS_ALUOP_LHU) ||
	                    (ex_aluop_i == `MIPS_ALUOP_LW);

	assign stall_o = ex_is_load && ((reg1_read_i && (ex_wd_i == reg1_addr_i)) ||
	                                (reg2_read_i && (ex_wd_i == reg2_addr_i)));

	always_comb begin
		reg1_o = select_operand(reg1_read_i, reg1_addr_i, reg1_data_i);
		reg2_o = select_operand(reg2_read_i, reg2_addr_i, reg2_data_i);
	end

endmodule

// File: src/inst_decoder.sv
`timescale 1ns/1ps
`include "mips_id_settings.svh"

module inst_decoder (
	input  mips_id_pkg::word_t     inst_i,
	output mips_id_pkg::aluop_t    aluop_o,
	output mips_id_pkg::alusel_t   alusel_o,
	output logic                   reg1_read_o,
	output logic                   reg2_read_o,
	output mips_id_pkg::reg_addr_t reg1_addr_o,
	output mips_id_pkg::reg_addr_t reg2_addr_o,
	output mips_id_pkg::reg_addr_t wd_o,
	output logic                   wreg_o,
	output mips_id_pkg::word_t     imm_o,
	output mips_id_pkg::br_kind_t  br_kind_o,
	output logic                   link_o
);

	logic [`MIPS_OP_W-1:0] op;
	logic [`MIPS_OP_W-1:0] funct;
	mips_id_pkg::reg_addr_t rs;
	mips_id_pkg::reg_addr_t rt;
	mips_id_pkg::reg_addr_t rd;

	assign op    = inst_i[31:26];
	assign funct = inst_i[5:0];
	assign rs    = inst_i[25:21];
	assign rt    = inst_i[20:16];
	assign rd    = inst_i[15:11];

	always_comb begin
		aluop_o     = `MIPS_ALUOP_NOP;
		alusel_o    = `MIPS_RES_NOP;
		reg1_read_o = 1'b0;
		reg2_read_o = 1'b0;
		reg1_addr_o = rs;
		reg2_addr_o = rt;
		wd_o        = rd;
		wreg_o      = 1'b0;
		imm_o       = '0;
		br_kind_o   = `MIPS_BR_NONE;
		link_o      = 1'b0;
		case (op)
			`MIPS_OP_SPECIAL: begin
				case (funct)
					`MIPS_FUNCT_AND:  aluop_o = `MIPS_ALUOP_AND;
					`MIPS_FUNCT_OR:   aluop_o = `MIPS_ALUOP_OR;
					`MIPS_FUNCT_XOR:  aluop_o = `MIPS_ALUOP_XOR;
					`MIPS_FUNCT_NOR:  aluop_o = `MIPS_ALUOP_NOR;
					`MIPS_FUNCT_SLLV: aluop_o = `MIPS_ALUOP_SLL;
					`MIPS_FUNCT_SRLV: aluop_o = `MIPS_ALUOP_SRL;
					`MIPS_FUNCT_SRAV: aluop_o = `MIPS_ALUOP_SRA;
					`MIPS_FUNCT_SLL:  aluop_o = (rs == '0) ? `MIPS_ALUOP_SLL : `MIPS_ALUOP_NOP;
					`MIPS_FUNCT_SRL:  aluop_o = (rs == '0) ? `MIPS_ALUOP_SRL : `MIPS_ALUOP_NOP;
					`MIPS_FUNCT_SRA:  aluop_o = (rs == '0) ? `MIPS_ALUOP_SRA : `MIPS_ALUOP_NOP;
					`MIPS_FUNCT_SLT:  aluop_o = `MIPS_ALUOP_SLT;
					`MIPS_FUNCT_SLTU: aluop_o = `MIPS_ALUOP_SLTU;
					`MIPS_FUNCT_ADD:  aluop_o = `MIPS_ALUOP_ADD;
					`MIPS_FUNCT_ADDU: aluop_o = `MIPS_ALUOP_ADDU;
					`MIPS_FUNCT_SUB:  aluop_o = `MIPS_ALUOP_SUB;
					`MIPS_FUNCT_SUBU: aluop_o = `MIPS_ALUOP_SUBU;
					`MIPS_FUNCT_JR:   aluop_o = `MIPS_ALUOP_JR;
					`MIPS_FUNCT_JALR: aluop_o = `MIPS_ALUOP_JALR;
					default: ;
				endcase
				if (aluop_o != `MIPS_ALUOP_NOP) begin
					reg1_read_o = 1'b1;
					reg2_read_o = 1'b1;
					wreg_o      = 1'b1;
					case (funct)
						`MIPS_FUNCT_AND, `MIPS_FUNCT_OR, `MIPS_FUNCT_XOR, `MIPS_FUNCT_NOR:
							alusel_o = `MIPS_RES_LOGIC;
						`MIPS_FUNCT_SLLV, `MIPS_FUNCT_SRLV, `MIPS_FUNCT_SRAV:
							alusel_o = `MIPS_RES_SHIFT;
						`MIPS_FUNCT_SLL, `MIPS_FUNCT_SRL, `MIPS_FUNCT_SRA: begin
							alusel_o    = `MIPS_RES_SHIFT;
							reg1_read_o = 1'b0;  // shamt rides in operand 1
							imm_o       = mips_id_pkg::word_t'(inst_i[10:6]);
						end
						`MIPS_FUNCT_JR, `MIPS_FUNCT_JALR: begin
							alusel_o    = `MIPS_RES_JUMP_BRANCH;
							reg2_read_o = 1'b0;
							wreg_o      = funct[0];  // only jalr links, to rd
							link_o      = funct[0];
							br_kind_o   = `MIPS_BR_JR;
						end
						default: alusel_o = `MIPS_RES_ARITHMETIC;
					endcase
				end
			end
			`MIPS_OP_ADDI, `MIPS_OP_ADDIU, `MIPS_OP_SLTI, `MIPS_OP_SLTIU,
			`MIPS_OP_ANDI, `MIPS_OP_ORI, `MIPS_OP_XORI, `MIPS_OP_LUI: begin
				case (op)
					`MIPS_OP_ADDI:  aluop_o = `MIPS_ALUOP_ADDI;
					`MIPS_OP_ADDIU: aluop_o = `MIPS_ALUOP_ADDIU;
					`MIPS_OP_SLTI:  aluop_o = `MIPS_ALUOP_SLT;
					`MIPS_OP_SLTIU: aluop_o = `MIPS_ALUOP_SLTU;
					`MIPS_OP_ANDI:  aluop_o = `MIPS_ALUOP_AND;
					`MIPS_OP_XORI:  aluop_o = `MIPS_ALUOP_XOR;
					default:        aluop_o = `MIPS_ALUOP_OR;  // ori, and lui as rs | imm
				endcase
				alusel_o    = op[2] ? `MIPS_RES_LOGIC : `MIPS_RES_ARITHMETIC;
				reg1_read_o = 1'b1;
				wreg_o      = 1'b1;
				wd_o        = rt;
				if (op == `MIPS_OP_LUI)
					imm_o = {inst_i[15:0], 16'h0};
				else if (op[2])
					imm_o = {16'h0, inst_i[15:0]};
				else
					imm_o = {{16{inst_i[15]}}, inst_i[15:0]};
			end
			`MIPS_OP_LB, `MIPS_OP_LBU, `MIPS_OP_LH, `MIPS_OP_LHU, `MIPS_OP_LW,
			`MIPS_OP_SB, `MIPS_OP_SH, `MIPS_OP_SW: begin
				case (op)
					`MIPS_OP_LB:  aluop_o = `MIPS_ALUOP_LB;
					`MIPS_OP_LBU: aluop_o = `MIPS_ALUOP_LBU;
					`MIPS_OP_LH:  aluop_o = `MIPS_ALUOP_LH;
					`MIPS_OP_LHU: aluop_o = `MIPS_ALUOP_LHU;
					`MIPS_OP_LW:  aluop_o = `MIPS_ALUOP_LW;
					`MIPS_OP_SB:  aluop_o = `MIPS_ALUOP_SB;
					`MIPS_OP_SH:  aluop_o = `MIPS_ALUOP_SH;
					default:      aluop_o = `MIPS_ALUOP_SW;
				endcase
				alusel_o    = `MIPS_RES_LOAD_STORE;
				reg1_read_o = 1'b1;
				reg2_read_o = op[3];  // opcode bit 3 marks a store
				wreg_o      = ~op[3];
				wd_o        = rt;
			end
			`MIPS_OP_J, `MIPS_OP_JAL: begin
				aluop_o   = op[0] ? `MIPS_ALUOP_JAL : `MIPS_ALUOP_J;
				alusel_o  = `MIPS_RES_JUMP_BRANCH;
				br_kind_o = `MIPS_BR_J;
				link_o    = op[0];
				wreg_o    = op[0];
				wd_o      = `MIPS_LINK_REG;
			end
			`MIPS_OP_BEQ, `MIPS_OP_BNE, `MIPS_OP_BLEZ, `MIPS_OP_BGTZ: begin
				case (op)
					`MIPS_OP_BEQ: aluop_o = `MIPS_ALUOP_BEQ;
					`MIPS_OP_BNE: aluop_o = `MIPS_ALUOP_BNE;
					`MIPS_OP_BLEZ: aluop_o = `MIPS_ALUOP_BLEZ;
					default:      aluop_o = `MIPS_ALUOP_BGTZ;
				endcase
				case (op)
					`MIPS_OP_BEQ: br_kind_o = `MIPS_BR_EQ;
					`MIPS_OP_BNE: br_kind_o = `MIPS_BR_NE;
					`MIPS_OP_BLEZ: br_kind_o = `MIPS_BR_LEZ;
					default:      br_kind_o = `MIPS_BR_GTZ;
				endcase
				alusel_o    = `MIPS_RES_JUMP_BRANCH;
				reg1_read_o = 1'b1;
				reg2_read_o = ~op[1];  // beq/bne compare two registers
			end
			`MIPS_OP_REGIMM: begin
				case (rt)
					`MIPS_RT_BLTZ:   aluop_o = `MIPS_ALUOP_BLTZ;
					`MIPS_RT_BGEZ:   aluop_o = `MIPS_ALUOP_BGEZ;
					`MIPS_RT_BLTZAL: aluop_o = `MIPS_ALUOP_BLTZAL;
					`MIPS_RT_BGEZAL: aluop_o = `MIPS_ALUOP_BGEZAL;
					default: ;
				endcase
				if (aluop_o != `MIPS_ALUOP_NOP) begin
					alusel_o    = `MIPS_RES_JUMP_BRANCH;
					reg1_read_o = 1'b1;
					br_kind_o   = rt[0] ? `MIPS_BR_GEZ : `MIPS_BR_LTZ;
					link_o      = rt[4];  // the -al forms
					wreg_o      = rt[4];
					wd_o        = `MIPS_LINK_REG;
				end
			end
			default: ;
		endcase
	end

endmodule

// File: src/mips_id_pkg.sv
`include "mips_id_settings.svh"

package mips_id_pkg;

	typedef logic [`MIPS_WORD_W-1:0]     word_t;      // data or address
	typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;  // gpr index
	typedef logic [`MIPS_ALUOP_W-1:0]    aluop_t;
	typedef logic [`MIPS_ALUSEL_W-1:0]   alusel_t;    // result group for EX
	typedef logic [`MIPS_BR_KIND_W-1:0]  br_kind_t;

endpackage

// File: include/mips_id_settings.svh
`ifndef MIPS_ID_SETTINGS_SVH
`define MIPS_ID_SETTINGS_SVH

`define MIPS_WORD_W     32
`define MIPS_REG_ADDR_W 5
`define MIPS_OP_W       6
`define MIPS_ALUOP_W    8
`define MIPS_ALUSEL_W   3
`define MIPS_BR_KIND_W  4
`define MIPS_LINK_REG   5'd31

// major opcodes, inst[31:26]
`define MIPS_OP_SPECIAL 6'b000000
`define MIPS_OP_REGIMM  6'b000001
`define MIPS_OP_J       6'b000010
`define MIPS_OP_JAL     6'b000011
`define MIPS_OP_BEQ     6'b000100
`define MIPS_OP_BNE     6'b000101
`define MIPS_OP_BLEZ    6'b000110
`define MIPS_OP_BGTZ    6'b000111
`define MIPS_OP_ADDI    6'b001000
`define MIPS_OP_ADDIU   6'b001001
`define MIPS_OP_SLTI    6'b001010
`define MIPS_OP_SLTIU   6'b001011
`define MIPS_OP_ANDI    6'b001100
`define MIPS_OP_ORI     6'b001101
`define MIPS_OP_XORI    6'b001110
`define MIPS_OP_LUI     6'b001111
`define MIPS_OP_LB      6'b100000
`define MIPS_OP_LH      6'b100001
`define MIPS_OP_LW      6'b100011
`define MIPS_OP_LBU     6'b100100
`define MIPS_OP_LHU     6'b100101
`define MIPS_OP_SB      6'b101000
`define MIPS_OP_SH      6'b101001
`define MIPS_OP_SW      6'b101011

// SPECIAL function field, inst[5:0]
`define MIPS_FUNCT_SLL  6'b000000
`define MIPS_FUNCT_SRL  6'b000010
`define MIPS_FUNCT_SRA  6'b000011
`define MIPS_FUNCT_SLLV 6'b000100
`define MIPS_FUNCT_SRLV 6'b000110
`define MIPS_FUNCT_SRAV 6'b000111
`define MIPS_FUNCT_JR   6'b001000
`define MIPS_FUNCT_JALR 6'b001001
`define MIPS_FUNCT_ADD  6'b100000
`define MIPS_FUNCT_ADDU 6'b100001
`define MIPS_FUNCT_SUB  6'b100010
`define MIPS_FUNCT_SUBU 6'b100011
`define MIPS_FUNCT_AND  6'b100100
`define MIPS_FUNCT_OR   6'b100101
`define MIPS_FUNCT_XOR  6'b100110
`define MIPS_FUNCT_NOR  6'b100111
`define MIPS_FUNCT_SLT  6'b101010
`define MIPS_FUNCT_SLTU 6'b101011

// REGIMM rt field
`define MIPS_RT_BLTZ   5'b00000
`define MIPS_RT_BGEZ   5'b00001
`define MIPS_RT_BLTZAL 5'b10000
`define MIPS_RT_BGEZAL 5'b10001

`define MIPS_ALUOP_NOP    8'b00000000
`define MIPS_ALUOP_AND    8'b00100100
`define MIPS_ALUOP_OR     8'b00100101
`define MIPS_ALUOP_XOR    8'b00100110
`define MIPS_ALUOP_NOR    8'b00100111
`define MIPS_ALUOP_SLL    8'b01111100
`define MIPS_ALUOP_SRL    8'b00000010
`define MIPS_ALUOP_SRA    8'b00000011
`define MIPS_ALUOP_SLT    8'b00101010
`define MIPS_ALUOP_SLTU   8'b00101011
`define MIPS_ALUOP_ADD    8'b00100000
`define MIPS_ALUOP_ADDU   8'b00100001
`define MIPS_ALUOP_SUB    8'b00100010
`define MIPS_ALUOP_SUBU   8'b00100011
`define MIPS_ALUOP_ADDI   8'b01010101
`define MIPS_ALUOP_ADDIU  8'b01010110
`define MIPS_ALUOP_J      8'b01001111
`define MIPS_ALUOP_JAL    8'b01010000
`define MIPS_ALUOP_JR     8'b00001000
`define MIPS_ALUOP_JALR   8'b00001001
`define MIPS_ALUOP_BEQ    8'b01010001
`define MIPS_ALUOP_BNE    8'b01010010
`define MIPS_ALUOP_BLEZ   8'b01010011
`define MIPS_ALUOP_BGTZ   8'b01010100
`define MIPS_ALUOP_BGEZ   8'b01000001
`define MIPS_ALUOP_BLTZ   8'b01000000
`define MIPS_ALUOP_BGEZAL 8'b01001011
`define MIPS_ALUOP_BLTZAL 8'b01001010
`define MIPS_ALUOP_LB     8'b11100000
`define MIPS_ALUOP_LBU    8'b11100100
`define MIPS_ALUOP_LH     8'b11100001
`define MIPS_ALUOP_LHU    8'b11100101
`define MIPS_ALUOP_LW     8'b11100011
`define MIPS_ALUOP_SB     8'b11101000
`define MIPS_ALUOP_SH     8'b11101001
`define MIPS_ALUOP_SW     8'b11101011

`define MIPS_RES_NOP         3'b000
`define MIPS_RES_LOGIC       3'b001
`define MIPS_RES_SHIFT       3'b010
`define MIPS_RES_ARITHMETIC  3'b100
`define MIPS_RES_JUMP_BRANCH 3'b110
`define MIPS_RES_LOAD_STORE  3'b111

`define MIPS_BR_NONE 4'd0
`define MIPS_BR_J    4'd1
`define MIPS_BR_JR   4'd2
`define MIPS_BR_EQ   4'd3
`define MIPS_BR_NE   4'd4
`define MIPS_BR_GTZ  4'd5
`define MIPS_BR_LEZ  4'd6
`define MIPS_BR_GEZ  4'd7
`define MIPS_BR_LTZ  4'd8

`endif
